/* include/tb_ref_model.svh */
/* Reference model for the external peripheral testbench, included inside its module.
   Needs ext_bus_pkg and power_pkg compiled first. */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam int KIND_MEM0 = 0;
localparam int KIND_MEM1 = 1;
localparam int KIND_PWR  = 2;
localparam int KIND_UNM  = 3;

// Memory word after a byte-selected write
function automatic ext_bus_pkg::data_t merge_word(input ext_bus_pkg::data_t old_w,
                                                  input ext_bus_pkg::data_t new_w,
                                                  input ext_bus_pkg::sel_t  sel);
  ext_bus_pkg::data_t res;
  res = old_w;
  for (int b = 0; b < ext_bus_pkg::SEL_W; b++) begin
    if (sel[b]) begin
      res[8*b +: 8] = new_w[8*b +: 8];
    end
  end
  return res;
endfunction

// Which slave answers an address
function automatic int decode_kind(input ext_bus_pkg::addr_t adr);
  ext_bus_pkg::slot_t slot;
  slot = adr[ext_bus_pkg::SLOT_MSB:ext_bus_pkg::SLOT_LSB];
  if (adr[ext_bus_pkg::ADDR_W-1:ext_bus_pkg::SLOT_MSB+1] != '0) begin
    return KIND_UNM;
  end
  if (slot == ext_bus_pkg::MEM0_SLOT) begin
    return KIND_MEM0;
  end
  if (slot == ext_bus_pkg::MEM1_SLOT) begin
    return KIND_MEM1;
  end
  if (slot == ext_bus_pkg::PWR_SLOT) begin
    return KIND_PWR;
  end
  return KIND_UNM;
endfunction

// Cycles from the request edge until ack is high
function automatic int ack_latency(input ext_bus_pkg::addr_t adr, input int mem_wait);
  int kind;
  kind = decode_kind(adr);
  if (kind == KIND_MEM0 || kind == KIND_MEM1) begin
    return mem_wait + 1;
  end
  return 1;
endfunction

// Switch register after a write into the power slot
function automatic power_pkg::domain_vec_t switch_after_write(
    input power_pkg::domain_vec_t old_sw,
    input ext_bus_pkg::addr_t     adr,
    input ext_bus_pkg::data_t     dat,
    input ext_bus_pkg::sel_t      sel);
  ext_bus_pkg::ofs_t ofs;
  ofs = adr[ext_bus_pkg::SLOT_LSB-1:ext_bus_pkg::WORD_LSB];
  if (sel[0] && ofs == ext_bus_pkg::PWR_SWITCH_OFS) begin
    return dat[power_pkg::N_DOMAINS-1:0];
  end
  return old_sw;
endfunction

// Wraps of the GPIO counter, the count holds while the input is low
function automatic int expected_events(input int high_cycles, input int cnt_max);
  return high_cycles / cnt_max;
endfunction

`endif

/* dv/tb_ext_periph.sv */
/* Self-checking testbench for ext_periph_top, MEM_WAIT 3, switch latency 15, CNT_MAX 16.
   Memory traffic stays in the first 16 words of each memory slot. */
`default_nettype none

module tb_ext_periph;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MEM_WAIT   = 3;
  localparam int ACK_LAT    = 15;
  localparam int CNT_MAX    = 16;
  localparam int CLK_PERIOD = 10;
  localparam int WIN_WORDS  = 16;
  localparam int N_RAND     = 200;
  localparam int N_UNM      = 12;
  localparam int N_STRETCH  = 12;
  localparam int ACK_LIMIT  = 32;
  localparam int N_TXN      = 4 * WIN_WORDS + N_RAND + 2 * N_UNM + 16;
  localparam int WD_CYCLES  = 2 * (N_TXN * (MEM_WAIT + 3) + N_STRETCH * 48 + 4 * ACK_LAT) + 8;

  logic                   clk_i;
  logic                   arst_n_i;
  logic                   wb_cyc_i;
  logic                   wb_stb_i;
  logic                   wb_we_i;
  ext_bus_pkg::sel_t      wb_sel_i;
  ext_bus_pkg::addr_t     wb_adr_i;
  ext_bus_pkg::data_t     wb_dat_i;
  ext_bus_pkg::data_t     wb_dat_o;
  logic                   wb_ack_o;
  logic                   gpio_i;
  logic                   gpio_evt_o;
  power_pkg::domain_vec_t pwr_switch_n_o;
  power_pkg::domain_vec_t pwr_ack_n_o;

  ext_bus_pkg::data_t     shadow [2][WIN_WORDS];
  power_pkg::domain_vec_t exp_switch;
  power_pkg::domain_vec_t sw_hist [$];
  string                  name_q [$];
  ext_bus_pkg::data_t     exp_q [$];
  ext_bus_pkg::data_t     act_q [$];
  time                    t_q [$];
  int                     n_checks = 0;
  int                     n_errors = 0;
  int                     n_evt = 0;

  `include "tb_ref_model.svh"

  ext_periph_top #(
    .MEM_WORDS         (1024),
    .MEM_WAIT          (MEM_WAIT),
    .SWITCH_ACK_LATENCY(ACK_LAT),
    .CNT_MAX           (CNT_MAX)
  ) dut_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_sel_i      (wb_sel_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .gpio_i        (gpio_i),
    .gpio_evt_o    (gpio_evt_o),
    .pwr_switch_n_o(pwr_switch_n_o),
    .pwr_ack_n_o   (pwr_ack_n_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic ext_bus_pkg::addr_t slot_addr(input ext_bus_pkg::slot_t slot,
                                                   input int word);
    ext_bus_pkg::addr_t adr;
    adr = '0;
    adr[ext_bus_pkg::SLOT_MSB:ext_bus_pkg::SLOT_LSB] = slot;
    adr[ext_bus_pkg::SLOT_LSB-1:ext_bus_pkg::WORD_LSB] = ext_bus_pkg::ofs_t'(word);
    return adr;
  endfunction

  function automatic ext_bus_pkg::slot_t mem_slot(input int m);
    return (m == 0) ? ext_bus_pkg::MEM0_SLOT : ext_bus_pkg::MEM1_SLOT;
  endfunction

  task automatic post_check(input string name, input ext_bus_pkg::data_t exp_v,
                            input ext_bus_pkg::data_t act_v);
    name_q.push_back(name);
    exp_q.push_back(exp_v);
    act_q.push_back(act_v);
    t_q.push_back($time);
  endtask

  // Bus master
  // ------------------------------
  task automatic bus_access(input logic we, input ext_bus_pkg::addr_t adr,
                            input ext_bus_pkg::data_t dat, input ext_bus_pkg::sel_t sel,
                            output ext_bus_pkg::data_t rdata,
                            output power_pkg::domain_vec_t sw);
    int lat;
    @(posedge clk_i);
    #1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_sel_i = sel;
    wb_adr_i = adr;
    wb_dat_i = dat;
    @(posedge clk_i);
    lat = 0;
    @(negedge clk_i);
    while (wb_ack_o !== 1'b1 && lat < ACK_LIMIT) begin
      @(posedge clk_i);
      lat++;
      @(negedge clk_i);
    end
    rdata = wb_dat_o;
    sw    = pwr_switch_n_o;
    assert (wb_ack_o === 1'b1) else begin
      n_errors++;
      $display("No ack within %0d cycles for the access to address %h", ACK_LIMIT, adr);
    end
    post_check("wb_ack_o latency", ack_latency(adr, MEM_WAIT), lat);
    @(posedge clk_i);
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic mem_write(input int m, input int idx, input ext_bus_pkg::data_t dat,
                           input ext_bus_pkg::sel_t sel);
    ext_bus_pkg::data_t     rd;
    power_pkg::domain_vec_t sw;
    bus_access(1'b1, slot_addr(mem_slot(m), idx), dat, sel, rd, sw);
    shadow[m][idx] = merge_word(shadow[m][idx], dat, sel);
  endtask

  task automatic mem_read(input int m, input int idx);
    ext_bus_pkg::data_t     rd;
    power_pkg::domain_vec_t sw;
    bus_access(1'b0, slot_addr(mem_slot(m), idx), '0, '1, rd, sw);
    post_check($sformatf("wb_dat_o mem%0d[%0d]", m, idx), shadow[m][idx], rd);
  endtask

  task automatic pwr_write(input int ofs, input ext_bus_pkg::data_t dat,
                           input ext_bus_pkg::sel_t sel);
    ext_bus_pkg::data_t     rd;
    power_pkg::domain_vec_t sw;
    ext_bus_pkg::addr_t     adr;
    adr = slot_addr(ext_bus_pkg::PWR_SLOT, ofs);
    exp_switch = switch_after_write(exp_switch, adr, dat, sel);
    bus_access(1'b1, adr, dat, sel, rd, sw);
    post_check("pwr_switch_n_o", exp_switch, sw);
  endtask

  task automatic pwr_read(input int ofs, input power_pkg::domain_vec_t exp_v);
    ext_bus_pkg::data_t     rd;
    power_pkg::domain_vec_t sw;
    bus_access(1'b0, slot_addr(ext_bus_pkg::PWR_SLOT, ofs), '0, '1, rd, sw);
    post_check($sformatf("wb_dat_o pwr[%0d]", ofs), ext_bus_pkg::data_t'(exp_v), rd);
    post_check("pwr_switch_n_o", exp_switch, sw);
  endtask

  // Monitors and compare
  // ------------------------------
  always @(negedge clk_i) begin
    if (arst_n_i === 1'b1) begin
      sw_hist.push_back(pwr_switch_n_o);
      post_check("pwr_ack_n_o", sw_hist.pop_front(), pwr_ack_n_o);
      if (gpio_evt_o === 1'b1) begin
        n_evt++;
      end
    end
  end

  initial begin : compare
    string              name;
    ext_bus_pkg::data_t exp_v;
    ext_bus_pkg::data_t act_v;
    time                t;
    forever begin
      wait (exp_q.size() != 0);
      name  = name_q.pop_front();
      exp_v = exp_q.pop_front();
      act_v = act_q.pop_front();
      t     = t_q.pop_front();
      n_checks++;
      assert (act_v === exp_v) else begin
        n_errors++;
        $display("FAILED time %0t: %s expected %h, got %h", t, name, exp_v, act_v);
      end
    end
  end

  initial begin : watchdog
    #(WD_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
    $display("test failed");
    $finish;
  end

  // Stimulus
  // ------------------------------
  initial begin : stimulus
    ext_bus_pkg::data_t     rd;
    ext_bus_pkg::data_t     wdat;
    ext_bus_pkg::addr_t     adr;
    ext_bus_pkg::addr_t     low;
    power_pkg::domain_vec_t sw;
    power_pkg::domain_vec_t prev_sw;
    int                     m;
    int                     idx;
    int                     i;
    int                     len;
    int                     high_cycles;
    void'($urandom(28));
    clk_i      = 1'b0;
    arst_n_i   = 1'b0;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_sel_i   = '0;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    gpio_i     = 1'b0;
    exp_switch = '0;
    for (i = 0; i < ACK_LAT; i++) begin
      sw_hist.push_back('0);
    end
    repeat (8) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    repeat (4) begin
      @(negedge clk_i);
      post_check("wb_ack_o", '0, wb_ack_o);
      post_check("gpio_evt_o", '0, gpio_evt_o);
      post_check("pwr_switch_n_o", '0, pwr_switch_n_o);
    end

    // Fill both windows, then random traffic
    for (m = 0; m < 2; m++) begin
      for (idx = 0; idx < WIN_WORDS; idx++) begin
        mem_write(m, idx, $urandom(), 4'hF);
      end
    end
    repeat (N_RAND) begin
      m   = $urandom_range(1, 0);
      idx = $urandom_range(WIN_WORDS - 1, 0);
      if ($urandom_range(1, 0) == 1) begin
        mem_write(m, idx, $urandom(), ext_bus_pkg::sel_t'($urandom()));
      end else begin
        mem_read(m, idx);
      end
    end

    // Unmapped slot 3 and aliases with upper bits set
    for (i = 0; i < N_UNM; i++) begin
      if (i % 2 == 0) begin
        adr = slot_addr(2'd3, $urandom_range(1023, 0));
      end else begin
        if ((i / 2) % 3 == 2) begin
          idx = ext_bus_pkg::PWR_SWITCH_OFS;
        end else begin
          idx = $urandom_range(WIN_WORDS - 1, 0);
        end
        low = slot_addr(ext_bus_pkg::slot_t'((i / 2) % 3), idx);
        adr = $urandom();
        adr[ext_bus_pkg::SLOT_MSB:0] = low[ext_bus_pkg::SLOT_MSB:0];
        adr[ext_bus_pkg::ADDR_W-1] = 1'b1;
      end
      wdat = $urandom();
      wdat[power_pkg::N_DOMAINS-1:0] = ~exp_switch;
      bus_access(1'b1, adr, wdat, 4'hF, rd, sw);
      bus_access(1'b0, adr, '0, 4'hF, rd, sw);
      post_check("wb_dat_o unmapped", ext_bus_pkg::UNMAPPED_RDATA, rd);
    end
    for (m = 0; m < 2; m++) begin
      for (idx = 0; idx < WIN_WORDS; idx++) begin
        mem_read(m, idx);
      end
    end
    pwr_read(ext_bus_pkg::PWR_SWITCH_OFS, exp_switch);

    // Power switch and its delayed acknowledge
    pwr_read(ext_bus_pkg::PWR_ACK_OFS, exp_switch);
    repeat (6) begin
      pwr_write(ext_bus_pkg::PWR_SWITCH_OFS, $urandom(), 4'hF);
    end
    pwr_write(ext_bus_pkg::PWR_ACK_OFS, $urandom(), 4'hF);
    repeat (ACK_LAT + 2) @(posedge clk_i);
    pwr_read(ext_bus_pkg::PWR_ACK_OFS, exp_switch);
    prev_sw = exp_switch;
    pwr_write(ext_bus_pkg::PWR_SWITCH_OFS, ext_bus_pkg::data_t'(~prev_sw), 4'hF);
    pwr_read(ext_bus_pkg::PWR_ACK_OFS, prev_sw);
    pwr_write(ext_bus_pkg::PWR_SWITCH_OFS, ext_bus_pkg::data_t'(prev_sw), 4'hE);
    pwr_read(5, '0);

    // GPIO stretches
    high_cycles = 0;
    repeat (N_STRETCH) begin
      len = $urandom_range(40, 1);
      @(posedge clk_i);
      #1;
      gpio_i = 1'b1;
      repeat (len) @(posedge clk_i);
      #1;
      gpio_i = 1'b0;
      high_cycles += len;
      repeat ($urandom_range(8, 1)) @(posedge clk_i);
    end
    repeat (4) @(posedge clk_i);
    #1;
    post_check("gpio_evt_o pulse count", expected_events(high_cycles, CNT_MAX), n_evt);

    repeat (4) @(posedge clk_i);
    wait (exp_q.size() == 0);
    #1;
    $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/ext_bus_demux.sv */
/* Routes one Wishbone cycle to mem0, mem1 or the power block by slot.
   Unmapped cycles are acked here one cycle late; writes are dropped. */
`default_nettype none

module ext_bus_demux (
  input  wire                      clk_i,
  input  wire                      arst_n_i,
  input  wire                      cyc_i,
  input  wire                      stb_i,
  input  wire                      we_i,
  input  wire ext_bus_pkg::sel_t   sel_i,
  input  wire ext_bus_pkg::addr_t  adr_i,
  input  wire ext_bus_pkg::data_t  dat_i,
  output ext_bus_pkg::data_t       dat_o,
  output logic                     ack_o,
  wb_if.master                     mem0_m,
  wb_if.master                     mem1_m,
  wb_if.master                     pwr_m
);

  ext_bus_pkg::slot_t slot;
  logic in_range;
  logic hit_mem0;
  logic hit_mem1;
  logic hit_pwr;
  logic hit_unm;
  logic unm_pend_q;
  logic unm_ack_q;

  // Decode
  // ------------------------------
  assign slot     = adr_i[ext_bus_pkg::SLOT_MSB:ext_bus_pkg::SLOT_LSB];
  assign in_range = (adr_i[ext_bus_pkg::ADDR_W-1:ext_bus_pkg::SLOT_MSB+1] == '0);
  assign hit_mem0 = in_range && (slot == ext_bus_pkg::MEM0_SLOT);
  assign hit_mem1 = in_range && (slot == ext_bus_pkg::MEM1_SLOT);
  assign hit_pwr  = in_range && (slot == ext_bus_pkg::PWR_SLOT);
  assign hit_unm  = !(hit_mem0 || hit_mem1 || hit_pwr);

  // Request fan-out, strobe only toward the hit slot
  assign mem0_m.cyc   = cyc_i && hit_mem0;
  assign mem0_m.stb   = stb_i && hit_mem0;
  assign mem0_m.we    = we_i;
  assign mem0_m.sel   = sel_i;
  assign mem0_m.adr   = adr_i;
  assign mem0_m.dat_w = dat_i;

  assign mem1_m.cyc   = cyc_i && hit_mem1;
  assign mem1_m.stb   = stb_i && hit_mem1;
  assign mem1_m.we    = we_i;
  assign mem1_m.sel   = sel_i;
  assign mem1_m.adr   = adr_i;
  assign mem1_m.dat_w = dat_i;

  assign pwr_m.cyc   = cyc_i && hit_pwr;
  assign pwr_m.stb   = stb_i && hit_pwr;
  assign pwr_m.we    = we_i;
  assign pwr_m.sel   = sel_i;
  assign pwr_m.adr   = adr_i;
  assign pwr_m.dat_w = dat_i;

  // Unmapped slot answer
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      unm_pend_q <= 1'b0;
      unm_ack_q  <= 1'b0;
    end else begin
      unm_ack_q  <= unm_pend_q;
      unm_pend_q <= cyc_i && stb_i && hit_unm && !unm_pend_q && !unm_ack_q;
    end
  end

  // Response mux
  // ------------------------------
  always_comb begin
    if (hit_mem0) begin
      dat_o = mem0_m.dat_r;
    end else if (hit_mem1) begin
      dat_o = mem1_m.dat_r;
    end else if (hit_pwr) begin
      dat_o = pwr_m.dat_r;
    end else begin
      dat_o = ext_bus_pkg::UNMAPPED_RDATA;
    end
  end

  assign ack_o = mem0_m.ack || mem1_m.ack || pwr_m.ack || unm_ack_q;

  a_single_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({mem0_m.ack, mem1_m.ack, pwr_m.ack, unm_ack_q}));

endmodule

`default_nettype wire

/* hw/ext_bus_pkg.sv */
/* External bus widths, word types and the slot address map.
   Slots are 4 KB each at bits 13:12; any set bit above 13 is unmapped. */
`default_nettype none

package ext_bus_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned SEL_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [SEL_W-1:0] sel_t;

  // Address map
  // ------------------------------
  localparam int unsigned WORD_LSB = 2;
  localparam int unsigned SLOT_MSB = 13;
  localparam int unsigned SLOT_LSB = 12;

  typedef logic [SLOT_MSB-SLOT_LSB:0] slot_t;

  localparam slot_t MEM0_SLOT = 2'd0;
  localparam slot_t MEM1_SLOT = 2'd1;
  localparam slot_t PWR_SLOT = 2'd2;

  localparam data_t UNMAPPED_RDATA = '0;

  // Word offset inside one slot
  typedef logic [SLOT_LSB-WORD_LSB-1:0] ofs_t;

  localparam ofs_t PWR_SWITCH_OFS = 'd0;
  localparam ofs_t PWR_ACK_OFS = 'd1;

endpackage

`default_nettype wire

/* hw/ext_periph_top.sv */
/* External slave side: Wishbone port to two slow RAMs and the power switch block,
   plus a free-running GPIO cycle counter. All switch lines are active low. */
`default_nettype none

module ext_periph_top #(
  parameter int unsigned MEM_WORDS          = 1024,
  parameter int unsigned MEM_WAIT           = 3,
  parameter int unsigned SWITCH_ACK_LATENCY = 15,
  parameter int unsigned CNT_MAX            = 2048
) (
  input  wire                      clk_i,
  input  wire                      arst_n_i,
  input  wire                      wb_cyc_i,
  input  wire                      wb_stb_i,
  input  wire                      wb_we_i,
  input  wire ext_bus_pkg::sel_t   wb_sel_i,
  input  wire ext_bus_pkg::addr_t  wb_adr_i,
  input  wire ext_bus_pkg::data_t  wb_dat_i,
  output ext_bus_pkg::data_t       wb_dat_o,
  output logic                     wb_ack_o,
  input  wire                      gpio_i,
  output logic                     gpio_evt_o,
  output power_pkg::domain_vec_t   pwr_switch_n_o,
  output power_pkg::domain_vec_t   pwr_ack_n_o
);

  wb_if #(
    .ADDR_W(ext_bus_pkg::ADDR_W),
    .DATA_W(ext_bus_pkg::DATA_W),
    .SEL_W (ext_bus_pkg::SEL_W)
  ) mem0_bus ();

  wb_if #(
    .ADDR_W(ext_bus_pkg::ADDR_W),
    .DATA_W(ext_bus_pkg::DATA_W),
    .SEL_W (ext_bus_pkg::SEL_W)
  ) mem1_bus ();

  wb_if #(
    .ADDR_W(ext_bus_pkg::ADDR_W),
    .DATA_W(ext_bus_pkg::DATA_W),
    .SEL_W (ext_bus_pkg::SEL_W)
  ) pwr_bus ();

  // Bus fabric
  // ------------------------------
  ext_bus_demux ext_bus_demux_i (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .cyc_i   (wb_cyc_i),
    .stb_i   (wb_stb_i),
    .we_i    (wb_we_i),
    .sel_i   (wb_sel_i),
    .adr_i   (wb_adr_i),
    .dat_i   (wb_dat_i),
    .dat_o   (wb_dat_o),
    .ack_o   (wb_ack_o),
    .mem0_m  (mem0_bus.master),
    .mem1_m  (mem1_bus.master),
    .pwr_m   (pwr_bus.master)
  );

  // Slaves
  // ------------------------------
  slow_memory #(
    .MEM_WORDS(MEM_WORDS),
    .MEM_WAIT (MEM_WAIT)
  ) slow_mem0_i (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .bus_s   (mem0_bus.slave)
  );

  slow_memory #(
    .MEM_WORDS(MEM_WORDS),
    .MEM_WAIT (MEM_WAIT)
  ) slow_mem1_i (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .bus_s   (mem1_bus.slave)
  );

  power_switch_emu #(
    .SWITCH_ACK_LATENCY(SWITCH_ACK_LATENCY)
  ) power_switch_emu_i (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .bus_s     (pwr_bus.slave),
    .switch_n_o(pwr_switch_n_o),
    .ack_n_o   (pwr_ack_n_o)
  );

  gpio_cnt #(
    .CNT_MAX(CNT_MAX)
  ) gpio_cnt_i (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .gpio_i  (gpio_i),
    .evt_o   (gpio_evt_o)
  );

endmodule

`default_nettype wire

/* hw/gpio_cnt.sv */
/* Counts cycles with gpio_i high, pulses evt_o for one cycle at each wrap.
   A low input holds the count. CNT_MAX should be at least 2. */
`default_nettype none

module gpio_cnt #(
  parameter int unsigned CNT_MAX = 2048
) (
  input  wire  clk_i,
  input  wire  arst_n_i,
  input  wire  gpio_i,
  output logic evt_o
);

  localparam int unsigned CNT_W = (CNT_MAX > 1) ? $clog2(CNT_MAX) : 1;

  logic [CNT_W-1:0] cnt_q;
  logic             evt_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
      evt_q <= 1'b0;
    end else begin
      evt_q <= 1'b0;
      if (gpio_i) begin
        if (cnt_q == CNT_W'(CNT_MAX - 1)) begin
          cnt_q <= '0;
          evt_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  assign evt_o = evt_q;

endmodule

`default_nettype wire

/* hw/power_pkg.sv */
/* Power domains driven by the switch emulation.
   Switch and acknowledge lines are active low: zero means powered. */
`default_nettype none

package power_pkg;

  // cpu, peripheral, external
  localparam int unsigned N_DOMAINS = 3;

  typedef logic [N_DOMAINS-1:0] domain_vec_t;

endpackage

`default_nettype wire

/* hw/power_switch_emu.sv */
/* Power switch register with an emulated switch acknowledge.
   SWITCH_ACK_LATENCY must be at least 1; only sel[0] guards the switch write. */
`default_nettype none

module power_switch_emu #(
  parameter int unsigned SWITCH_ACK_LATENCY = 15
) (
  input  wire                      clk_i,
  input  wire                      arst_n_i,
  wb_if.slave                      bus_s,
  output power_pkg::domain_vec_t   switch_n_o,
  output power_pkg::domain_vec_t   ack_n_o
);

  ext_bus_pkg::ofs_t      ofs;
  logic                   pend_q;
  logic                   ack_q;
  power_pkg::domain_vec_t switch_q;
  power_pkg::domain_vec_t ack_line_q [SWITCH_ACK_LATENCY];

  assign ofs = bus_s.adr[ext_bus_pkg::SLOT_LSB-1:ext_bus_pkg::WORD_LSB];

  // Bus handshake and switch register
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q   <= 1'b0;
      ack_q    <= 1'b0;
      switch_q <= '0;
    end else begin
      ack_q  <= pend_q;
      pend_q <= bus_s.cyc && bus_s.stb && !pend_q && !ack_q;
      if (pend_q && bus_s.we && bus_s.sel[0] && (ofs == ext_bus_pkg::PWR_SWITCH_OFS)) begin
        switch_q <= bus_s.dat_w[power_pkg::N_DOMAINS-1:0];
      end
    end
  end

  // Switch acknowledge delay line
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        ack_line_q[i] <= '0;
      end
    end else begin
      ack_line_q[0] <= switch_q;
      for (int i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        ack_line_q[i] <= ack_line_q[i-1];
      end
    end
  end

  assign switch_n_o = switch_q;
  assign ack_n_o    = ack_line_q[SWITCH_ACK_LATENCY-1];

  always_comb begin
    bus_s.dat_r = '0;
    if (ofs == ext_bus_pkg::PWR_SWITCH_OFS) begin
      bus_s.dat_r[power_pkg::N_DOMAINS-1:0] = switch_q;
    end else if (ofs == ext_bus_pkg::PWR_ACK_OFS) begin
      bus_s.dat_r[power_pkg::N_DOMAINS-1:0] = ack_n_o;
    end
  end

  assign bus_s.ack = ack_q;

  // Ack answers a live request and falls on the next cycle
  a_ack_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bus_s.ack |=> !bus_s.ack && $past(bus_s.cyc && bus_s.stb));

endmodule

`default_nettype wire

/* hw/slow_memory.sv */
/* Word RAM behind a Wishbone slave, acked MEM_WAIT+1 cycles after the request.
   MEM_WORDS must be a power of two and no more than the 1024 words of a slot. */
`default_nettype none

module slow_memory #(
  parameter int unsigned MEM_WORDS = 1024,
  parameter int unsigned MEM_WAIT  = 3
) (
  input  wire  clk_i,
  input  wire  arst_n_i,
  wb_if.slave  bus_s
);

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);
  localparam int unsigned CNT_W = (MEM_WAIT > 0) ? $clog2(MEM_WAIT + 1) : 1;

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    ACK
  } state_e;

  state_e             state_q;
  logic [CNT_W-1:0]   cnt_q;
  logic [IDX_W-1:0]   word_idx;
  logic               done;
  ext_bus_pkg::data_t mem_q [MEM_WORDS];
  ext_bus_pkg::data_t rdata_q;

  assign word_idx = bus_s.adr[ext_bus_pkg::WORD_LSB +: IDX_W];
  assign done     = (state_q == WAIT) && (cnt_q == CNT_W'(MEM_WAIT));

  // Wait-state FSM
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (bus_s.cyc && bus_s.stb) begin
            state_q <= WAIT;
            cnt_q   <= '0;
          end
        end
        WAIT: begin
          if (done) begin
            state_q <= ACK;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Storage, written and read on the last wait cycle
  always_ff @(posedge clk_i) begin
    if (done) begin
      rdata_q <= mem_q[word_idx];
      if (bus_s.we) begin
        for (int b = 0; b < ext_bus_pkg::SEL_W; b++) begin
          if (bus_s.sel[b]) begin
            mem_q[word_idx][8*b +: 8] <= bus_s.dat_w[8*b +: 8];
          end
        end
      end
    end
  end

  assign bus_s.ack   = (state_q == ACK);
  assign bus_s.dat_r = rdata_q;

  a_ack_has_stb: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bus_s.ack |-> bus_s.stb);

endmodule

`default_nettype wire

/* hw/wb_if.sv */
/* Wishbone classic request and response, no err, rty or tags.
   Widths are set by the instantiating level. */
`default_nettype none

interface wb_if #(
  parameter int unsigned ADDR_W = 32,
  parameter int unsigned DATA_W = 32,
  parameter int unsigned SEL_W  = 4
);

  logic              cyc;
  logic              stb;
  logic              we;
  logic [SEL_W-1:0]  sel;
  logic [ADDR_W-1:0] adr;
  logic [DATA_W-1:0] dat_w;
  logic [DATA_W-1:0] dat_r;
  logic              ack;

  modport master (
    output cyc, stb, we, sel, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, sel, adr, dat_w,
    output dat_r, ack
  );

endinterface

`default_nettype wire

/* project.f */
+incdir+include
hw/ext_bus_pkg.sv
hw/power_pkg.sv
hw/wb_if.sv
hw/ext_bus_demux.sv
hw/slow_memory.sv
hw/power_switch_emu.sv
hw/gpio_cnt.sv
hw/ext_periph_top.sv
dv/tb_ext_periph.sv
